//--- files.f
+incdir+rtl
rtl/mmu_pkg.sv
rtl/mmu_csr.sv
rtl/mmu_tlb.sv
rtl/mmu_ptw.sv
rtl/mmu_ctrl.sv
rtl/mmu_top.sv
verification/mmu_checker.sv
verification/tb_mmu.sv

//--- verification/tb_mmu.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tb_mmu;
    import mmu_pkg::*;

    localparam int period = 100;
    localparam int n_csr = 40;
    localparam int n_bare = 20;
    localparam int n_sv39 = 60;
    localparam int n_tlb = 10;
    localparam int n_flush = 5;
    localparam int n_credit = 10;
    localparam int num_trans = 1 + n_csr + n_bare + n_sv39 + 2 * n_tlb + 3 * n_flush
                             + n_credit;
    localparam ppn_t root_ppn = 44'h80000;

    logic       clk;
    logic       rstn;
    logic       req_valid;
    xlen_t      req_vaddr;
    logic       req_ready;
    logic       resp_valid;
    paddr_t     resp_paddr;
    logic       resp_fault;
    logic       csr_wr;
    logic [11:0] csr_waddr;
    logic [11:0] csr_raddr;
    xlen_t      csr_sdata;
    xlen_t      csr_cdata;
    xlen_t      csr_rdata;
    logic       mem_req_valid;
    paddr_t     mem_req_addr;
    logic       mem_credit;
    logic       mem_resp_valid;
    pte_t       mem_resp_data;

    integer seed = 2;
    int     cyc = 0;
    bit     withhold = 0;
    xlen_t  satp_model;
    ppn_t   next_table;

    // sparse page table memory, absent entries read as zero
    pte_t   mem [paddr_t];
    int     resp_due[$];
    pte_t   resp_data[$];
    int     credit_due[$];

    // pte addresses read by the last reference walk
    paddr_t walk_addrs[$];

    mmu_top uut (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req_vaddr      (req_vaddr),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_paddr     (resp_paddr),
        .resp_fault     (resp_fault),
        .csr_wr         (csr_wr),
        .csr_waddr      (csr_waddr),
        .csr_raddr      (csr_raddr),
        .csr_sdata      (csr_sdata),
        .csr_cdata      (csr_cdata),
        .csr_rdata      (csr_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_credit     (mem_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    mmu_checker chk (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .resp_valid    (resp_valid),
        .resp_paddr    (resp_paddr),
        .resp_fault    (resp_fault),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_credit    (mem_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function xlen_t rnd64();
        return {$random(seed), $random(seed)};
    endfunction

    function pte_t read_pte(input paddr_t a);
        return mem.exists(a) ? mem[a] : 64'h0;
    endfunction

    function pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {10'b0, ppn, 2'b00, flags};
    endfunction

    // flags: 0xcb leaf, 0x01 pointer, 0x05 W without R, 0x02 invalid
    task automatic build_table(input ppn_t tbl, input int lvl);
        ppn_t child;
        ppn_t leaf;
        int   kind;
        for (int i = 0; i < 8; i++) begin
            kind = rnd(8);
            leaf = ppn_t'(rnd64());
            if (lvl == 2) leaf[17:0] = '0;
            if (lvl == 1) leaf[8:0] = '0;
            case (kind)
                0: mem[{tbl, 9'(i), 3'b0}] = make_pte(leaf, 8'h02);
                1, 2: mem[{tbl, 9'(i), 3'b0}] = make_pte(leaf, 8'hcb);
                6: mem[{tbl, 9'(i), 3'b0}] = make_pte(leaf, 8'h05);
                7: mem[{tbl, 9'(i), 3'b0}] = make_pte(leaf | 44'h1, 8'hcb);
                default: begin
                    child = next_table;
                    next_table++;
                    mem[{tbl, 9'(i), 3'b0}] = make_pte(child, 8'h01);
                    if (lvl > 0) build_table(child, lvl - 1);
                end
            endcase
        end
    endtask

    // software Sv39 walk over the memory model
    task automatic ref_walk(input xlen_t va, input ppn_t root, output paddr_t pa,
                            output bit fault);
        ppn_t   a;
        pte_t   pte;
        paddr_t mask;
        paddr_t ra;
        a = root;
        pa = '0;
        fault = 1'b1;
        walk_addrs.delete();
        for (int lvl = 2; lvl >= 0; lvl--) begin
            ra = {a, va[12 + 9 * lvl +: 9], 3'b0};
            walk_addrs.push_back(ra);
            pte = read_pte(ra);
            if (!pte[0] || (pte[2] && !pte[1])) return;
            if (pte[1] || pte[3]) begin
                mask = (56'h1 << (12 + 9 * lvl)) - 1;
                if (({pte[53:10], 12'b0} & mask) != 0) return;
                pa = {pte[53:10], 12'b0} | (va[55:0] & mask);
                fault = 1'b0;
                return;
            end
            a = pte[53:10];
        end
    endtask

    function xlen_t sv39_vaddr();
        return {25'b0, 6'b0, 3'(rnd(8)), 6'b0, 3'(rnd(8)), 6'b0, 3'(rnd(8)),
                12'(rnd(4096))};
    endfunction

    // memory: in-order answers after 1 to 4 cycles, credits after a delay
    always @(negedge clk) begin
        int due;
        if (rstn && mem_req_valid) begin
            due = cyc + 2 + rnd(4);
            if (resp_due.size() > 0 && due <= resp_due[$]) due = resp_due[$] + 1;
            resp_due.push_back(due);
            resp_data.push_back(read_pte(mem_req_addr));
            credit_due.push_back(cyc + 2 + (withhold ? 8 + rnd(5) : rnd(4)));
        end
    end

    always @(posedge clk) begin
        #1;
        mem_resp_valid = 1'b0;
        mem_credit = 1'b0;
        if (resp_due.size() > 0 && resp_due[0] <= cyc) begin
            mem_resp_valid = 1'b1;
            mem_resp_data = resp_data.pop_front();
            void'(resp_due.pop_front());
        end
        // at most one credit per cycle
        for (int i = 0; i < credit_due.size(); i++) begin
            if (credit_due[i] <= cyc) begin
                mem_credit = 1'b1;
                credit_due.delete(i);
                break;
            end
        end
    end

    task write_satp(input xlen_t sdata, input xlen_t cdata);
        csr_wr = 1'b1;
        csr_waddr = `CSR_SATP_ADDR;
        csr_sdata = sdata;
        csr_cdata = cdata;
        @(posedge clk);
        #1;
        csr_wr = 1'b0;
    endtask

    task automatic translate(input xlen_t va, input paddr_t pa, input bit fault,
                             input int lat, input int memmode);
        chk.clear_reads();
        foreach (walk_addrs[i]) begin
            chk.expect_read(walk_addrs[i]);
        end
        chk.expect_resp(pa, fault, lat, memmode);
        req_valid = 1'b1;
        req_vaddr = va;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        @(negedge clk);
        while (!resp_valid) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic find_mapped(output xlen_t va, output paddr_t pa);
        bit fault;
        for (int t = 0; t < 200; t++) begin
            va = sv39_vaddr();
            ref_walk(va, root_ppn, pa, fault);
            if (!fault) return;
        end
        chk.report_error("page table has no mapped address");
    endtask

    initial begin
        xlen_t  va;
        xlen_t  s;
        xlen_t  c;
        xlen_t  nxt;
        paddr_t pa;
        bit     fault;

        rstn = 1'b0;
        req_valid = 1'b0;
        req_vaddr = '0;
        csr_wr = 1'b0;
        csr_waddr = '0;
        csr_raddr = `CSR_SATP_ADDR;
        csr_sdata = '0;
        csr_cdata = '0;
        mem_credit = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        next_table = root_ppn + 1;
        build_table(root_ppn, 2);

        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        chk.check_value("req_ready", req_ready, 1);
        chk.check_value("resp_valid", resp_valid, 0);
        chk.check_value("mem_req_valid", mem_req_valid, 0);
        chk.check_value("satp after reset", csr_rdata, 0);
        chk.finish_test("reset");
        @(posedge clk);
        #1;

        satp_model = '0;
        for (int i = 0; i < n_csr; i++) begin
            s = rnd64();
            c = rnd64();
            if (rnd(2)) begin
                c[63:60] = 4'hf;
                s[63:60] = rnd(2) ? `SATP_MODE_SV39 : `SATP_MODE_BARE;
            end
            nxt = (satp_model & ~c) | s;
            if (nxt[63:60] == `SATP_MODE_BARE || nxt[63:60] == `SATP_MODE_SV39) begin
                satp_model = nxt;
            end
            write_satp(s, c);
            csr_raddr = `CSR_SATP_ADDR;
            #1;
            chk.check_value("satp readback", csr_rdata, satp_model);
            csr_raddr = 12'(rnd(4096));
            if (csr_raddr == `CSR_SATP_ADDR) csr_raddr = 12'h181;
            #1;
            chk.check_value("other csr read", csr_rdata, 0);
            csr_raddr = `CSR_SATP_ADDR;
        end
        chk.finish_test("csr");

        write_satp('0, '1);
        for (int i = 0; i < n_bare; i++) begin
            va = rnd64();
            translate(va, va[55:0], 1'b0, 2, 1);
        end
        chk.finish_test("bare");

        satp_model = {`SATP_MODE_SV39, 16'h0001, root_ppn};
        write_satp(satp_model, '1);
        for (int i = 0; i < n_sv39; i++) begin
            va = sv39_vaddr();
            ref_walk(va, root_ppn, pa, fault);
            translate(va, pa, fault, 0, 0);
        end
        chk.finish_test("sv39");

        for (int i = 0; i < n_tlb; i++) begin
            find_mapped(va, pa);
            translate(va, pa, 1'b0, 0, 0);
            translate(va, pa, 1'b0, 2, 1);
        end
        chk.finish_test("tlb_hit");

        for (int i = 0; i < n_flush; i++) begin
            find_mapped(va, pa);
            translate(va, pa, 1'b0, 0, 0);
            translate(va, pa, 1'b0, 2, 1);
            satp_model[59:44] = satp_model[59:44] + 1;
            write_satp(satp_model, '1);
            translate(va, pa, 1'b0, 0, 2);
        end
        chk.finish_test("tlb_flush");

        // slow credit return keeps the walker starved
        withhold = 1'b1;
        satp_model[59:44] = satp_model[59:44] + 1;
        write_satp(satp_model, '1);
        for (int i = 0; i < n_credit; i++) begin
            va = sv39_vaddr();
            ref_walk(va, root_ppn, pa, fault);
            translate(va, pa, fault, 0, 0);
        end
        withhold = 1'b0;
        chk.finish_test("credits");

        $display("tests: %0d, errors: %0d", chk.tests, chk.errors);
        if (chk.errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(num_trans * 40 * period);
        $display("watchdog expired, simulation did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- verification/mmu_checker.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_checker (
    input  logic             clk,
    input  logic             rstn,
    input  logic             req_valid,
    input  logic             req_ready,
    input  logic             resp_valid,
    input  mmu_pkg::paddr_t  resp_paddr,
    input  logic             resp_fault,
    input  logic             mem_req_valid,
    input  mmu_pkg::paddr_t  mem_req_addr,
    input  logic             mem_credit
);
    import mmu_pkg::*;

    int errors = 0;
    int tests = 0;
    int test_start_errors = 0;

    // expected responses, one per request in flight
    paddr_t exp_paddr[$];
    bit     exp_fault[$];
    int     exp_lat[$];
    int     exp_mem[$];

    // page table addresses the current walk should read, in order
    paddr_t exp_addr[$];

    int ncyc = 0;
    int accept_cyc = 0;
    int mem_count = 0;
    int outstanding = 0;
    bit busy = 1'b0;

    // lat 0 means any latency; mem 0 any, 1 none, 2 at least one read
    task expect_resp(input paddr_t pa, input bit fault, input int lat, input int mem);
        exp_paddr.push_back(pa);
        exp_fault.push_back(fault);
        exp_lat.push_back(lat);
        exp_mem.push_back(mem);
    endtask

    task clear_reads();
        exp_addr.delete();
    endtask

    task expect_read(input paddr_t a);
        exp_addr.push_back(a);
    endtask

    task check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task report_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task finish_test(input string name);
        tests++;
        $display("test %-10s : %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // sample at the falling edge, away from the drive points
    always @(negedge clk) begin
        ncyc++;
        if (rstn) begin
            if (busy && req_ready) begin
                report_error("req_ready high while a request is in flight");
            end
            if (req_valid && req_ready) begin
                accept_cyc = ncyc;
                mem_count = 0;
                busy = 1'b1;
            end
            if (mem_req_valid) begin
                mem_count++;
                if (outstanding >= `MMU_MEM_CREDITS) begin
                    report_error("memory request issued with no credit left");
                end
                if (exp_addr.size() == 0) begin
                    report_error("page table read where the walk expects none");
                end else begin
                    check_value("mem_req_addr", mem_req_addr, exp_addr.pop_front());
                end
            end
            outstanding = outstanding + (mem_req_valid ? 1 : 0) - (mem_credit ? 1 : 0);
            if (resp_valid) begin
                busy = 1'b0;
                if (exp_paddr.size() == 0) begin
                    report_error("response arrived with no request pending");
                end else begin
                    check_value("resp_paddr", resp_paddr, exp_paddr.pop_front());
                    check_value("resp_fault", resp_fault, exp_fault.pop_front());
                    if (exp_lat[0] != 0 && ncyc - accept_cyc != exp_lat[0]) begin
                        report_error($sformatf("response latency %0d cycles, expected %0d",
                                               ncyc - accept_cyc - 1, exp_lat[0] - 1));
                    end
                    if (exp_mem[0] == 1 && mem_count != 0) begin
                        report_error("memory read issued where none was expected");
                    end
                    if (exp_mem[0] == 2 && mem_count == 0) begin
                        report_error("no page table read after a TLB flush");
                    end
                    void'(exp_lat.pop_front());
                    void'(exp_mem.pop_front());
                end
            end
        end
    end

endmodule

//--- rtl/mmu_top.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_top (
    input  logic             clk,
    input  logic             rstn,
    input  logic             req_valid,
    input  mmu_pkg::xlen_t   req_vaddr,
    output logic             req_ready,
    output logic             resp_valid,
    output mmu_pkg::paddr_t  resp_paddr,
    output logic             resp_fault,
    input  logic             csr_wr,
    input  logic [11:0]      csr_waddr,
    input  logic [11:0]      csr_raddr,
    input  mmu_pkg::xlen_t   csr_sdata,
    input  mmu_pkg::xlen_t   csr_cdata,
    output mmu_pkg::xlen_t   csr_rdata,
    output logic             mem_req_valid,
    output mmu_pkg::paddr_t  mem_req_addr,
    input  logic             mem_credit,
    input  logic             mem_resp_valid,
    input  mmu_pkg::pte_t    mem_resp_data
);
    import mmu_pkg::*;

    ppn_t       satp_ppn;
    asid_t      satp_asid;
    satp_mode_t satp_mode;
    logic       satp_changed;

    vpn_t       lookup_vpn;
    logic       hit;
    ppn_t       hit_ppn;
    pt_level_t  hit_level;

    logic       walk_start;
    vpn_t       walk_vpn;
    logic       walk_done;
    ppn_t       walk_ppn;
    pt_level_t  walk_level;
    logic       walk_fault;

    logic       tlb_fill;
    vpn_t       fill_vpn;
    ppn_t       fill_ppn;
    pt_level_t  fill_level;

    mmu_csr u_csr (
        .clk          (clk),
        .rstn         (rstn),
        .csr_wr       (csr_wr),
        .csr_waddr    (csr_waddr),
        .csr_raddr    (csr_raddr),
        .csr_sdata    (csr_sdata),
        .csr_cdata    (csr_cdata),
        .csr_rdata    (csr_rdata),
        .satp_ppn     (satp_ppn),
        .satp_asid    (satp_asid),
        .satp_mode    (satp_mode),
        .satp_changed (satp_changed)
    );

    mmu_ctrl u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_vaddr  (req_vaddr),
        .satp_mode  (satp_mode),
        .hit        (hit),
        .hit_ppn    (hit_ppn),
        .hit_level  (hit_level),
        .walk_done  (walk_done),
        .walk_ppn   (walk_ppn),
        .walk_level (walk_level),
        .walk_fault (walk_fault),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_paddr (resp_paddr),
        .resp_fault (resp_fault),
        .lookup_vpn (lookup_vpn),
        .walk_start (walk_start),
        .walk_vpn   (walk_vpn),
        .tlb_fill   (tlb_fill),
        .fill_vpn   (fill_vpn),
        .fill_ppn   (fill_ppn),
        .fill_level (fill_level)
    );

    // a satp write drops every cached translation
    mmu_tlb #(
        .entries (`MMU_TLB_ENTRIES)
    ) u_tlb (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (satp_changed),
        .lookup_vpn (lookup_vpn),
        .asid       (satp_asid),
        .fill       (tlb_fill),
        .fill_vpn   (fill_vpn),
        .fill_ppn   (fill_ppn),
        .fill_level (fill_level),
        .hit        (hit),
        .hit_ppn    (hit_ppn),
        .hit_level  (hit_level)
    );

    mmu_ptw u_ptw (
        .clk            (clk),
        .rstn           (rstn),
        .walk_start     (walk_start),
        .walk_vpn       (walk_vpn),
        .satp_ppn       (satp_ppn),
        .mem_credit     (mem_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .walk_done      (walk_done),
        .walk_ppn       (walk_ppn),
        .walk_level     (walk_level),
        .walk_fault     (walk_fault)
    );

endmodule

//--- rtl/mmu_ctrl.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_ctrl (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req_valid,
    input  mmu_pkg::xlen_t      req_vaddr,
    input  mmu_pkg::satp_mode_t satp_mode,
    input  logic                hit,
    input  mmu_pkg::ppn_t       hit_ppn,
    input  mmu_pkg::pt_level_t  hit_level,
    input  logic                walk_done,
    input  mmu_pkg::ppn_t       walk_ppn,
    input  mmu_pkg::pt_level_t  walk_level,
    input  logic                walk_fault,
    output logic                req_ready,
    output logic                resp_valid,
    output mmu_pkg::paddr_t     resp_paddr,
    output logic                resp_fault,
    output mmu_pkg::vpn_t       lookup_vpn,
    output logic                walk_start,
    output mmu_pkg::vpn_t       walk_vpn,
    output logic                tlb_fill,
    output mmu_pkg::vpn_t       fill_vpn,
    output mmu_pkg::ppn_t       fill_ppn,
    output mmu_pkg::pt_level_t  fill_level
);
    import mmu_pkg::*;

    typedef enum logic [1:0] {st_idle, st_lookup, st_walk, st_respond} ctrl_state_t;

    ctrl_state_t state;
    xlen_t       vaddr_q;
    logic        sv39;

    // keep vpn bits below the leaf level plus the page offset
    function automatic paddr_t make_paddr(input ppn_t ppn, input pt_level_t lvl,
                                          input xlen_t va);
        paddr_t pa;
        case (lvl)
            2'd2:    pa = {ppn[43:18], va[29:0]};
            2'd1:    pa = {ppn[43:9], va[20:0]};
            default: pa = {ppn, va[11:0]};
        endcase
        return pa;
    endfunction

    assign sv39       = satp_mode == `SATP_MODE_SV39;
    assign req_ready  = state == st_idle;
    assign resp_valid = state == st_respond;

    assign lookup_vpn = vaddr_q[38:12];
    assign walk_vpn   = vaddr_q[38:12];
    assign fill_vpn   = vaddr_q[38:12];
    assign fill_ppn   = walk_ppn;
    assign fill_level = walk_level;

    assign walk_start = state == st_lookup && sv39 && !hit;
    // faulting walks never reach the TLB
    assign tlb_fill   = state == st_walk && walk_done && !walk_fault;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: state <= walk_start ? st_walk : st_respond;
                st_walk: begin
                    if (walk_done) begin
                        state <= st_respond;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            vaddr_q <= req_vaddr;
        end
        if (state == st_lookup && !sv39) begin
            resp_paddr <= vaddr_q[55:0];
            resp_fault <= 1'b0;
        end else if (state == st_lookup && hit) begin
            resp_paddr <= make_paddr(hit_ppn, hit_level, vaddr_q);
            resp_fault <= 1'b0;
        end else if (state == st_walk && walk_done) begin
            resp_paddr <= walk_fault ? '0 : make_paddr(walk_ppn, walk_level, vaddr_q);
            resp_fault <= walk_fault;
        end
    end

    // walker only finishes a walk this FSM started
    a_done_in_walk: assert property (@(posedge clk) disable iff (!rstn)
        walk_done |-> state == st_walk);

endmodule

//--- rtl/mmu_ptw.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_ptw (
    input  logic                clk,
    input  logic                rstn,
    input  logic                walk_start,
    input  mmu_pkg::vpn_t       walk_vpn,
    input  mmu_pkg::ppn_t       satp_ppn,
    input  logic                mem_credit,
    input  logic                mem_resp_valid,
    input  mmu_pkg::pte_t       mem_resp_data,
    output logic                mem_req_valid,
    output mmu_pkg::paddr_t     mem_req_addr,
    output logic                walk_done,
    output mmu_pkg::ppn_t       walk_ppn,
    output mmu_pkg::pt_level_t  walk_level,
    output logic                walk_fault
);
    import mmu_pkg::*;

    localparam int cred_w = $clog2(`MMU_MEM_CREDITS + 1);

    typedef enum logic [1:0] {ptw_idle, ptw_req, ptw_wait} ptw_state_t;

    ptw_state_t        state;
    pt_level_t         level;
    ppn_t              base;
    vpn_t              vpn;
    logic [cred_w-1:0] credits;
    logic [8:0]        vpn_idx;
    ppn_t              pte_ppn;
    logic              pte_leaf;
    logic              misaligned;
    logic              pte_fault;

    always_comb begin
        case (level)
            2'd2:    vpn_idx = vpn[26:18];
            2'd1:    vpn_idx = vpn[17:9];
            default: vpn_idx = vpn[8:0];
        endcase
    end

    // only issue with a credit in hand
    assign mem_req_valid = state == ptw_req && credits != '0;
    assign mem_req_addr  = {base, vpn_idx, 3'b000};

    assign pte_ppn    = mem_resp_data[53:10];
    assign pte_leaf   = mem_resp_data[1] | mem_resp_data[3];
    assign misaligned = (level == 2'd2 && pte_ppn[17:0] != '0)
                     || (level == 2'd1 && pte_ppn[8:0] != '0);
    // invalid, W without R, misaligned superpage, or pointer at level 0
    assign pte_fault  = !mem_resp_data[0]
                     || (mem_resp_data[2] && !mem_resp_data[1])
                     || (pte_leaf && misaligned)
                     || (!pte_leaf && level == 2'd0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= cred_w'(`MMU_MEM_CREDITS);
        end else begin
            credits <= credits + cred_w'(mem_credit) - cred_w'(mem_req_valid);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= ptw_idle;
            walk_done <= 1'b0;
        end else begin
            walk_done <= 1'b0;
            case (state)
                ptw_idle: begin
                    if (walk_start) begin
                        state <= ptw_req;
                    end
                end
                ptw_req: begin
                    if (mem_req_valid) begin
                        state <= ptw_wait;
                    end
                end
                ptw_wait: begin
                    if (mem_resp_valid) begin
                        if (pte_fault || pte_leaf) begin
                            walk_done <= 1'b1;
                            state     <= ptw_idle;
                        end else begin
                            state <= ptw_req;
                        end
                    end
                end
                default: state <= ptw_idle;
            endcase
        end
    end

    // walk context and result
    always_ff @(posedge clk) begin
        if (state == ptw_idle && walk_start) begin
            base  <= satp_ppn;
            vpn   <= walk_vpn;
            level <= 2'd2;
        end else if (state == ptw_wait && mem_resp_valid) begin
            if (pte_fault || pte_leaf) begin
                walk_ppn   <= pte_ppn;
                walk_level <= level;
                walk_fault <= pte_fault;
            end else begin
                base  <= pte_ppn;
                level <= level - 2'd1;
            end
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!rstn)
        credits <= cred_w'(`MMU_MEM_CREDITS) && !(mem_req_valid && credits == '0));

endmodule

//--- rtl/mmu_tlb.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_tlb #(
    parameter int entries = `MMU_TLB_ENTRIES
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                flush,
    input  mmu_pkg::vpn_t       lookup_vpn,
    input  mmu_pkg::asid_t      asid,
    input  logic                fill,
    input  mmu_pkg::vpn_t       fill_vpn,
    input  mmu_pkg::ppn_t       fill_ppn,
    input  mmu_pkg::pt_level_t  fill_level,
    output logic                hit,
    output mmu_pkg::ppn_t       hit_ppn,
    output mmu_pkg::pt_level_t  hit_level
);
    import mmu_pkg::*;

    localparam int idx_w = entries > 1 ? $clog2(entries) : 1;

    logic [entries-1:0] valid;
    vpn_t               tag_vpn    [entries];
    asid_t              tag_asid   [entries];
    ppn_t               data_ppn   [entries];
    pt_level_t          data_level [entries];
    logic [entries-1:0] match;
    logic [idx_w-1:0]   victim;

    // superpages skip the low vpn fields
    always_comb begin
        for (int i = 0; i < entries; i++) begin
            match[i] = valid[i]
                    && tag_asid[i] == asid
                    && tag_vpn[i][26:18] == lookup_vpn[26:18]
                    && (data_level[i] == 2'd2 || tag_vpn[i][17:9] == lookup_vpn[17:9])
                    && (data_level[i] != 2'd0 || tag_vpn[i][8:0] == lookup_vpn[8:0]);
        end
    end

    assign hit = |match;

    // match is one-hot, so an OR of the selected entries is enough
    always_comb begin
        hit_ppn   = '0;
        hit_level = '0;
        for (int i = 0; i < entries; i++) begin
            if (match[i]) begin
                hit_ppn   = hit_ppn | data_ppn[i];
                hit_level = hit_level | data_level[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid  <= '0;
            victim <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (fill) begin
            valid[victim] <= 1'b1;
            if (victim == idx_w'(entries - 1)) begin
                victim <= '0;
            end else begin
                victim <= victim + 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (fill && !flush) begin
            tag_vpn[victim]    <= fill_vpn;
            tag_asid[victim]   <= asid;
            data_ppn[victim]   <= fill_ppn;
            data_level[victim] <= fill_level;
        end
    end

    a_single_hit: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(match));

endmodule

//--- rtl/mmu_csr.sv
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_csr (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 csr_wr,
    input  logic [11:0]          csr_waddr,
    input  logic [11:0]          csr_raddr,
    input  mmu_pkg::xlen_t       csr_sdata,
    input  mmu_pkg::xlen_t       csr_cdata,
    output mmu_pkg::xlen_t       csr_rdata,
    output mmu_pkg::ppn_t        satp_ppn,
    output mmu_pkg::asid_t       satp_asid,
    output mmu_pkg::satp_mode_t  satp_mode,
    output logic                 satp_changed
);
    import mmu_pkg::*;

    xlen_t      satp;
    ppn_t       next_ppn;
    asid_t      next_asid;
    satp_mode_t next_mode;
    logic       mode_ok;
    logic       wr_commit;

    assign satp = {satp_mode, satp_asid, satp_ppn};

    // old value, clear mask removed, set mask added
    assign next_ppn  = (satp_ppn & ~csr_cdata[`SATP_PPN_MSB:`SATP_PPN_LSB])
                     | csr_sdata[`SATP_PPN_MSB:`SATP_PPN_LSB];
    assign next_asid = (satp_asid & ~csr_cdata[`SATP_ASID_MSB:`SATP_ASID_LSB])
                     | csr_sdata[`SATP_ASID_MSB:`SATP_ASID_LSB];
    assign next_mode = (satp_mode & ~csr_cdata[`SATP_MODE_MSB:`SATP_MODE_LSB])
                     | csr_sdata[`SATP_MODE_MSB:`SATP_MODE_LSB];

    // WARL: unsupported mode drops the whole write
    assign mode_ok   = next_mode == `SATP_MODE_BARE || next_mode == `SATP_MODE_SV39;
    assign wr_commit = csr_wr && csr_waddr == `CSR_SATP_ADDR && mode_ok;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            satp_ppn     <= '0;
            satp_asid    <= '0;
            satp_mode    <= `SATP_MODE_BARE;
            satp_changed <= 1'b0;
        end else begin
            satp_changed <= wr_commit;
            if (wr_commit) begin
                satp_ppn  <= next_ppn;
                satp_asid <= next_asid;
                satp_mode <= next_mode;
            end
        end
    end

    always_comb begin
        csr_rdata = '0;
        if (csr_raddr == `CSR_SATP_ADDR) begin
            csr_rdata = satp;
        end
    end

    a_mode_legal: assert property (@(posedge clk) disable iff (!rstn)
        satp_mode == `SATP_MODE_BARE || satp_mode == `SATP_MODE_SV39);

endmodule

//--- rtl/mmu_pkg.sv
`include "mmu_defs.svh"

package mmu_pkg;

    // csr data and virtual address
    typedef logic [`MMU_XLEN-1:0] xlen_t;

    // sv39 physical address
    typedef logic [55:0] paddr_t;

    // physical page number
    typedef logic [43:0] ppn_t;

    // three 9-bit vpn fields
    typedef logic [26:0] vpn_t;

    typedef logic [15:0] asid_t;

    typedef logic [3:0] satp_mode_t;

    // raw page table entry
    typedef logic [63:0] pte_t;

    // 2 is a 1 GiB page, 0 a 4 KiB page
    typedef logic [1:0] pt_level_t;

endpackage

//--- rtl/mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// datapath width of the core
`define MMU_XLEN            64

// number of TLB entries
`define MMU_TLB_ENTRIES     8

// page table reads the memory accepts before a credit comes back
`define MMU_MEM_CREDITS     2

// satp CSR address
`define CSR_SATP_ADDR       12'h180

// satp mode encodings
`define SATP_MODE_BARE      4'd0
`define SATP_MODE_SV39      4'd8

// satp field positions, RV64 layout
`define SATP_PPN_LSB        0
`define SATP_PPN_MSB        43
`define SATP_ASID_LSB       44
`define SATP_ASID_MSB       59
`define SATP_MODE_LSB       60
`define SATP_MODE_MSB       63

`endif
